// ==== id_pkg.sv ====
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t LINK_REG  = 5'd31;
    localparam word_t     ZERO_WORD = 32'h0000_0000;
    localparam word_t     PC_STEP   = 32'd4;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
        OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
    } opcode_e;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03,
        FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
        FN_JR   = 6'h08, FN_JALR = 6'h09,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
        FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    // REGIMM rt field, inst[20:16]
    typedef enum logic [4:0] {
        RI_BLTZ = 5'h00, RI_BGEZ = 5'h01, RI_BLTZAL = 5'h10, RI_BGEZAL = 5'h11
    } regimm_e;

    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_AND  = 8'h24, ALU_OR   = 8'h25, ALU_XOR   = 8'h26, ALU_NOR    = 8'h27,
        ALU_SLL  = 8'h7c, ALU_SRL  = 8'h02, ALU_SRA   = 8'h03,
        ALU_ADD  = 8'h20, ALU_ADDU = 8'h21, ALU_SUB   = 8'h22, ALU_SUBU   = 8'h23,
        ALU_SLT  = 8'h2a, ALU_SLTU = 8'h2b, ALU_ADDI  = 8'h55, ALU_ADDIU  = 8'h56,
        ALU_J    = 8'h4f, ALU_JAL  = 8'h50, ALU_JR    = 8'h08, ALU_JALR   = 8'h09,
        ALU_BEQ  = 8'h51, ALU_BNE  = 8'h52, ALU_BGTZ  = 8'h54, ALU_BLEZ   = 8'h53,
        ALU_BLTZ = 8'h40, ALU_BGEZ = 8'h41, ALU_BLTZAL = 8'h4a, ALU_BGEZAL = 8'h4b,
        ALU_LB   = 8'he0, ALU_LBU  = 8'he4, ALU_LH    = 8'he1, ALU_LHU    = 8'he5,
        ALU_LW   = 8'he3, ALU_SB   = 8'he8, ALU_SH    = 8'he9, ALU_SW     = 8'heb
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110,
        SEL_LOAD_STORE  = 3'b111
    } alu_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_ALWAYS_IMM26, BR_ALWAYS_REG, BR_EQ, BR_NE,
        BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZ
    } br_kind_e;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        logic      wreg;
        reg_addr_t wd;
        logic      reg1_read;
        logic      reg2_read;
        word_t     imm;
        br_kind_e  br_kind;
        logic      link;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_e   aluop;
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     reg1;
        word_t     reg2;
        logic      wreg;
        reg_addr_t wd;
        word_t     link_addr;
        word_t     inst;
    } id_ex_t;

    localparam dec_ctrl_t CTRL_NOP = '{aluop: ALU_NOP, alusel: SEL_NOP, br_kind: BR_NONE,
                                       default: '0};
    localparam id_ex_t ID_EX_BUBBLE = '{aluop: ALU_NOP, alusel: SEL_NOP, default: '0};

endpackage

`default_nettype wire

// ==== inst_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  logic              rst_i,
    input  id_pkg::word_t     inst_i,
    output id_pkg::dec_ctrl_t ctrl_o
);
    import id_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    regimm_e   rt_code;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    assign opcode  = opcode_e'(inst_i[31:26]);
    assign funct   = funct_e'(inst_i[5:0]);
    assign rt_code = regimm_e'(inst_i[20:16]);
    assign rs      = inst_i[25:21];
    assign rt      = inst_i[20:16];
    assign rd      = inst_i[15:11];

    function automatic dec_ctrl_t ctl(input alu_op_e op, input alu_sel_e sel,
                                      input logic wreg, input reg_addr_t wd,
                                      input logic rd1, input logic rd2,
                                      input br_kind_e br = BR_NONE);
        dec_ctrl_t c;
        c = CTRL_NOP;
        c.aluop     = op;
        c.alusel    = sel;
        c.wreg      = wreg;
        c.wd        = wd;
        c.reg1_read = rd1;
        c.reg2_read = rd2;
        c.br_kind   = br;
        // only jal, jalr, bltzal, bgezal write while branching
        c.link      = wreg && (br != BR_NONE);
        return c;
    endfunction

    always_comb begin
        ctrl_o = CTRL_NOP;
        if (!rst_i) begin
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_AND:  ctrl_o = ctl(ALU_AND, SEL_LOGIC, 1'b1, rd, 1'b1, 1'b1);
                        FN_OR:   ctrl_o = ctl(ALU_OR, SEL_LOGIC, 1'b1, rd, 1'b1, 1'b1);
                        FN_XOR:  ctrl_o = ctl(ALU_XOR, SEL_LOGIC, 1'b1, rd, 1'b1, 1'b1);
                        FN_NOR:  ctrl_o = ctl(ALU_NOR, SEL_LOGIC, 1'b1, rd, 1'b1, 1'b1);
                        FN_SLLV: ctrl_o = ctl(ALU_SLL, SEL_SHIFT, 1'b1, rd, 1'b1, 1'b1);
                        FN_SRLV: ctrl_o = ctl(ALU_SRL, SEL_SHIFT, 1'b1, rd, 1'b1, 1'b1);
                        FN_SRAV: ctrl_o = ctl(ALU_SRA, SEL_SHIFT, 1'b1, rd, 1'b1, 1'b1);
                        FN_SLL:  ctrl_o = ctl(ALU_SLL, SEL_SHIFT, 1'b1, rd, 1'b0, 1'b1);
                        FN_SRL:  ctrl_o = ctl(ALU_SRL, SEL_SHIFT, 1'b1, rd, 1'b0, 1'b1);
                        FN_SRA:  ctrl_o = ctl(ALU_SRA, SEL_SHIFT, 1'b1, rd, 1'b0, 1'b1);
                        FN_ADD:  ctrl_o = ctl(ALU_ADD, SEL_ARITH, 1'b1, rd, 1'b1, 1'b1);
                        FN_ADDU: ctrl_o = ctl(ALU_ADDU, SEL_ARITH, 1'b1, rd, 1'b1, 1'b1);
                        FN_SUB:  ctrl_o = ctl(ALU_SUB, SEL_ARITH, 1'b1, rd, 1'b1, 1'b1);
                        FN_SUBU: ctrl_o = ctl(ALU_SUBU, SEL_ARITH, 1'b1, rd, 1'b1, 1'b1);
                        FN_SLT:  ctrl_o = ctl(ALU_SLT, SEL_ARITH, 1'b1, rd, 1'b1, 1'b1);
                        FN_SLTU: ctrl_o = ctl(ALU_SLTU, SEL_ARITH, 1'b1, rd, 1'b1, 1'b1);
                        FN_JR:   ctrl_o = ctl(ALU_JR, SEL_JUMP_BRANCH, 1'b0, '0, 1'b1, 1'b0,
                                              BR_ALWAYS_REG);
                        FN_JALR: ctrl_o = ctl(ALU_JALR, SEL_JUMP_BRANCH, 1'b1, rd, 1'b1, 1'b0,
                                              BR_ALWAYS_REG);
                        default: ctrl_o = CTRL_NOP;
                    endcase
                    // fixed shifts need rs zero, shamt goes out as operand 1
                    if (funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
                        if (rs == '0) begin
                            ctrl_o.imm = {27'd0, inst_i[10:6]};
                        end else begin
                            ctrl_o = CTRL_NOP;
                        end
                    end
                end
                OP_REGIMM: begin
                    case (rt_code)
                        RI_BLTZ:   ctrl_o = ctl(ALU_BLTZ, SEL_JUMP_BRANCH, 1'b0, '0,
                                                1'b1, 1'b0, BR_LTZ);
                        RI_BGEZ:   ctrl_o = ctl(ALU_BGEZ, SEL_JUMP_BRANCH, 1'b0, '0,
                                                1'b1, 1'b0, BR_GEZ);
                        RI_BLTZAL: ctrl_o = ctl(ALU_BLTZAL, SEL_JUMP_BRANCH, 1'b1, LINK_REG,
                                                1'b1, 1'b0, BR_LTZ);
                        RI_BGEZAL: ctrl_o = ctl(ALU_BGEZAL, SEL_JUMP_BRANCH, 1'b1, LINK_REG,
                                                1'b1, 1'b0, BR_GEZ);
                        default:   ctrl_o = CTRL_NOP;
                    endcase
                end
                OP_J:     ctrl_o = ctl(ALU_J, SEL_JUMP_BRANCH, 1'b0, '0, 1'b0, 1'b0,
                                       BR_ALWAYS_IMM26);
                OP_JAL:   ctrl_o = ctl(ALU_JAL, SEL_JUMP_BRANCH, 1'b1, LINK_REG, 1'b0, 1'b0,
                                       BR_ALWAYS_IMM26);
                OP_BEQ:   ctrl_o = ctl(ALU_BEQ, SEL_JUMP_BRANCH, 1'b0, '0, 1'b1, 1'b1, BR_EQ);
                OP_BNE:   ctrl_o = ctl(ALU_BNE, SEL_JUMP_BRANCH, 1'b0, '0, 1'b1, 1'b1, BR_NE);
                OP_BLEZ:  ctrl_o = ctl(ALU_BLEZ, SEL_JUMP_BRANCH, 1'b0, '0, 1'b1, 1'b0, BR_LEZ);
                OP_BGTZ:  ctrl_o = ctl(ALU_BGTZ, SEL_JUMP_BRANCH, 1'b0, '0, 1'b1, 1'b0, BR_GTZ);
                OP_ADDI:  ctrl_o = ctl(ALU_ADDI, SEL_ARITH, 1'b1, rt, 1'b1, 1'b0);
                OP_ADDIU: ctrl_o = ctl(ALU_ADDIU, SEL_ARITH, 1'b1, rt, 1'b1, 1'b0);
                OP_SLTI:  ctrl_o = ctl(ALU_SLT, SEL_ARITH, 1'b1, rt, 1'b1, 1'b0);
                OP_SLTIU: ctrl_o = ctl(ALU_SLTU, SEL_ARITH, 1'b1, rt, 1'b1, 1'b0);
                OP_ANDI:  ctrl_o = ctl(ALU_AND, SEL_LOGIC, 1'b1, rt, 1'b1, 1'b0);
                OP_ORI:   ctrl_o = ctl(ALU_OR, SEL_LOGIC, 1'b1, rt, 1'b1, 1'b0);
                OP_XORI:  ctrl_o = ctl(ALU_XOR, SEL_LOGIC, 1'b1, rt, 1'b1, 1'b0);
                // lui is an or with the shifted immediate
                OP_LUI:   ctrl_o = ctl(ALU_OR, SEL_LOGIC, 1'b1, rt, 1'b1, 1'b0);
                OP_LB:    ctrl_o = ctl(ALU_LB, SEL_LOAD_STORE, 1'b1, rt, 1'b1, 1'b0);
                OP_LBU:   ctrl_o = ctl(ALU_LBU, SEL_LOAD_STORE, 1'b1, rt, 1'b1, 1'b0);
                OP_LH:    ctrl_o = ctl(ALU_LH, SEL_LOAD_STORE, 1'b1, rt, 1'b1, 1'b0);
                OP_LHU:   ctrl_o = ctl(ALU_LHU, SEL_LOAD_STORE, 1'b1, rt, 1'b1, 1'b0);
                OP_LW:    ctrl_o = ctl(ALU_LW, SEL_LOAD_STORE, 1'b1, rt, 1'b1, 1'b0);
                OP_SB:    ctrl_o = ctl(ALU_SB, SEL_LOAD_STORE, 1'b0, '0, 1'b1, 1'b1);
                OP_SH:    ctrl_o = ctl(ALU_SH, SEL_LOAD_STORE, 1'b0, '0, 1'b1, 1'b1);
                OP_SW:    ctrl_o = ctl(ALU_SW, SEL_LOAD_STORE, 1'b0, '0, 1'b1, 1'b1);
                default:  ctrl_o = CTRL_NOP;
            endcase

            case (opcode)
                OP_ANDI, OP_ORI, OP_XORI: ctrl_o.imm = {16'h0000, inst_i[15:0]};
                OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: ctrl_o.imm = {{16{inst_i[15]}}, inst_i[15:0]};
                OP_LUI:   ctrl_o.imm = {inst_i[15:0], 16'h0000};
                default:  ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== operand_forward.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_forward (
    input  id_pkg::dec_ctrl_t ctrl_i,
    input  id_pkg::word_t     inst_i,
    input  id_pkg::word_t     reg1_data_i,
    input  id_pkg::word_t     reg2_data_i,
    input  id_pkg::fwd_t      ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    output id_pkg::word_t     reg1_o,
    output id_pkg::word_t     reg2_o,
    output logic              stall_o
);
    import id_pkg::*;

    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    logic      ex_is_load;

    // youngest result wins, immediate when the port is not read
    function automatic word_t select_operand(input logic rd, input reg_addr_t addr,
                                             input word_t rf_data, input word_t imm,
                                             input fwd_t ex_src, input fwd_t mem_src);
        word_t op;
        if (!rd) begin
            op = imm;
        end else if (ex_src.wreg && ex_src.wd == addr) begin
            op = ex_src.wdata;
        end else if (mem_src.wreg && mem_src.wd == addr) begin
            op = mem_src.wdata;
        end else begin
            op = rf_data;
        end
        return op;
    endfunction

    assign reg1_addr = inst_i[25:21];
    assign reg2_addr = inst_i[20:16];

    assign reg1_o = select_operand(ctrl_i.reg1_read, reg1_addr, reg1_data_i, ctrl_i.imm,
                                   ex_fwd_i, mem_fwd_i);
    assign reg2_o = select_operand(ctrl_i.reg2_read, reg2_addr, reg2_data_i, ctrl_i.imm,
                                   ex_fwd_i, mem_fwd_i);

    assign ex_is_load = ex_fwd_i.aluop inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};

    // load data only exists after mem, so the ex value is not usable yet
    assign stall_o = ex_is_load &&
                     ((ctrl_i.reg1_read && reg1_addr == ex_fwd_i.wd) ||
                      (ctrl_i.reg2_read && reg2_addr == ex_fwd_i.wd));

endmodule

`default_nettype wire

// ==== branch_resolve.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_resolve (
    input  id_pkg::dec_ctrl_t ctrl_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     inst_i,
    input  id_pkg::word_t     reg1_i,
    input  id_pkg::word_t     reg2_i,
    output logic              branch_flag_o,
    output id_pkg::word_t     branch_target_o,
    output id_pkg::word_t     link_addr_o
);
    import id_pkg::*;

    word_t pc_plus_4;
    word_t br_offset;

    assign pc_plus_4 = pc_i + PC_STEP;
    assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

    // return lands past the delay slot
    assign link_addr_o = ctrl_i.link ? pc_plus_4 + PC_STEP : ZERO_WORD;

    always_comb begin
        branch_flag_o   = 1'b1;
        branch_target_o = pc_plus_4 + br_offset;
        case (ctrl_i.br_kind)
            BR_NONE:         branch_flag_o = 1'b0;
            BR_ALWAYS_IMM26: branch_target_o = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
            BR_ALWAYS_REG:   branch_target_o = reg1_i;
            BR_EQ:           branch_flag_o = (reg1_i == reg2_i);
            BR_NE:           branch_flag_o = (reg1_i != reg2_i);
            BR_GTZ:          branch_flag_o = !reg1_i[31] && (reg1_i != ZERO_WORD);
            BR_LEZ:          branch_flag_o = reg1_i[31] || (reg1_i == ZERO_WORD);
            BR_LTZ:          branch_flag_o = reg1_i[31];
            BR_GEZ:          branch_flag_o = !reg1_i[31];
            default:         branch_flag_o = 1'b0;
        endcase
        // target only meaningful when taken
        if (!branch_flag_o) begin
            branch_target_o = ZERO_WORD;
        end
    end

endmodule

`default_nettype wire

// ==== id_ex_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stall_i,
    input  id_pkg::dec_ctrl_t ctrl_i,
    input  id_pkg::word_t     reg1_i,
    input  id_pkg::word_t     reg2_i,
    input  id_pkg::word_t     link_addr_i,
    input  id_pkg::word_t     inst_i,
    output id_pkg::id_ex_t    id_ex_o
);
    import id_pkg::*;

    always_ff @(posedge clk) begin
        if (rst_i || stall_i) begin
            // stalled instruction comes back next cycle
            id_ex_o <= ID_EX_BUBBLE;
        end else begin
            id_ex_o.aluop     <= ctrl_i.aluop;
            id_ex_o.alusel    <= ctrl_i.alusel;
            id_ex_o.reg1      <= reg1_i;
            id_ex_o.reg2      <= reg2_i;
            id_ex_o.wreg      <= ctrl_i.wreg;
            id_ex_o.wd        <= ctrl_i.wd;
            id_ex_o.link_addr <= link_addr_i;
            // loads and stores need the offset and rt later
            id_ex_o.inst      <= inst_i;
        end
    end

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  id_pkg::word_t         pc_i,
    input  id_pkg::word_t         inst_i,
    input  id_pkg::word_t         reg1_data_i,
    input  id_pkg::word_t         reg2_data_i,
    input  id_pkg::fwd_t          ex_fwd_i,
    input  id_pkg::fwd_t          mem_fwd_i,
    output id_pkg::reg_addr_t     reg1_addr_o,
    output id_pkg::reg_addr_t     reg2_addr_o,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output logic                  stall_o,
    output logic                  branch_flag_o,
    output id_pkg::word_t         branch_target_o,
    output id_pkg::id_ex_t        id_ex_o
);
    import id_pkg::*;

    dec_ctrl_t ctrl;
    word_t     reg1;
    word_t     reg2;
    word_t     link_addr;

    assign reg1_addr_o = inst_i[25:21];
    assign reg2_addr_o = inst_i[20:16];
    assign reg1_read_o = ctrl.reg1_read;
    assign reg2_read_o = ctrl.reg2_read;

    inst_decoder u_inst_decoder (
        .rst_i  (rst_i),
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    operand_forward u_operand_forward (
        .ctrl_i      (ctrl),
        .inst_i      (inst_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_o      (reg1),
        .reg2_o      (reg2),
        .stall_o     (stall_o)
    );

    branch_resolve u_branch_resolve (
        .ctrl_i          (ctrl),
        .pc_i            (pc_i),
        .inst_i          (inst_i),
        .reg1_i          (reg1),
        .reg2_i          (reg2),
        .branch_flag_o   (branch_flag_o),
        .branch_target_o (branch_target_o),
        .link_addr_o     (link_addr)
    );

    id_ex_reg u_id_ex_reg (
        .clk         (clk),
        .rst_i       (rst_i),
        .stall_i     (stall_o),
        .ctrl_i      (ctrl),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .link_addr_i (link_addr),
        .inst_i      (inst_i),
        .id_ex_o     (id_ex_o)
    );

endmodule

`default_nettype wire

// ==== id_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_props (
    input logic           clk,
    input logic           rst_i,
    input logic           stall_o,
    input logic           reg1_read_o,
    input logic           reg2_read_o,
    input id_pkg::id_ex_t id_ex_o
);
    import id_pkg::*;

    int fail_count = 0;

    a_reset_no_write: assert property (@(posedge clk) rst_i |=> !id_ex_o.wreg)
        else begin
            $error("id_ex_o.wreg set after a reset cycle");
            fail_count++;
        end

    // a stalled cycle leaves a bubble behind
    a_stall_bubble: assert property (@(posedge clk) stall_o |=> id_ex_o.aluop == ALU_NOP)
        else begin
            $error("id_ex_o.aluop not NOP after a stall");
            fail_count++;
        end

    a_reset_no_read: assert property (@(posedge clk) rst_i |-> !reg1_read_o && !reg2_read_o)
        else begin
            $error("register read enable high during reset");
            fail_count++;
        end

endmodule

bind id_stage id_props u_id_props (.*);

`default_nettype wire

// ==== id_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_checker (
    input  logic              clk,
    input  logic              check_en_i,
    input  id_pkg::word_t     exp_inst_i,
    input  logic [3:0]        exp_flags_i,
    input  id_pkg::word_t     exp_target_i,
    input  id_pkg::id_ex_t    exp_id_ex_i,
    input  id_pkg::reg_addr_t reg1_addr_o,
    input  id_pkg::reg_addr_t reg2_addr_o,
    input  logic              reg1_read_o,
    input  logic              reg2_read_o,
    input  logic              stall_o,
    input  logic              branch_flag_o,
    input  id_pkg::word_t     branch_target_o,
    input  id_pkg::id_ex_t    id_ex_o,
    output int                checks_o,
    output int                errors_o
);
    import id_pkg::*;

    logic   prev_en = 1'b0;
    id_ex_t prev_exp;

    initial begin
        checks_o = 0;
        errors_o = 0;
    end

    task automatic check_val(input string name, input logic [159:0] exp,
                             input logic [159:0] act);
        checks_o++;
        if (act !== exp) begin
            errors_o++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // inputs change on the falling edge, so the rising edge sees settled values
    always @(posedge clk) begin
        if (check_en_i) begin
            check_val("reg1_addr_o", exp_inst_i[25:21], reg1_addr_o);
            check_val("reg2_addr_o", exp_inst_i[20:16], reg2_addr_o);
            check_val("reg1_read_o", exp_flags_i[3], reg1_read_o);
            check_val("reg2_read_o", exp_flags_i[2], reg2_read_o);
            check_val("stall_o", exp_flags_i[1], stall_o);
            check_val("branch_flag_o", exp_flags_i[0], branch_flag_o);
            check_val("branch_target_o", exp_target_i, branch_target_o);
        end
        // register output still holds what the previous edge loaded
        if (prev_en) begin
            check_val("id_ex_o", prev_exp, id_ex_o);
        end
        prev_en  <= check_en_i;
        prev_exp <= exp_id_ex_i;
    end

endmodule

`default_nettype wire

// ==== tb_id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    typedef struct packed {
        word_t      inst;
        word_t      pc;
        word_t      r1d;
        word_t      r2d;
        fwd_t       ex;
        fwd_t       mem;
        logic       rnd;
        logic [3:0] fl;
        word_t      tgt;
        id_ex_t     idex;
    } row_t;

    localparam word_t R1  = 32'h1111_1111;
    localparam word_t R2  = 32'h2222_2222;
    localparam word_t PC0 = 32'h0040_0100;
    localparam word_t P8  = 32'h0040_0108;
    localparam alu_sel_e JB = SEL_JUMP_BRANCH;
    localparam alu_sel_e LS = SEL_LOAD_STORE;

    logic      clk = 1'b0;
    logic      rst_i;
    word_t     pc, inst, reg1_data, reg2_data;
    fwd_t      ex_fwd, mem_fwd;
    reg_addr_t reg1_addr, reg2_addr;
    logic      reg1_read, reg2_read, stall, branch_flag;
    word_t     branch_target;
    id_ex_t    id_ex;
    logic      check_en;
    logic [3:0] exp_flags;
    word_t     exp_target;
    id_ex_t    exp_id_ex;
    int        checks, errors;
    integer    seed = 32'h15fe3529;
    row_t      rows[$];
    logic      rows_loaded = 1'b0;
    word_t     cur_pc;
    fwd_t      cur_ex, cur_mem;
    logic      cur_rnd;

    always #4 clk = ~clk;

    id_stage dut (
        .clk(clk), .rst_i(rst_i), .pc_i(pc), .inst_i(inst),
        .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd),
        .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
        .reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
        .stall_o(stall), .branch_flag_o(branch_flag),
        .branch_target_o(branch_target), .id_ex_o(id_ex)
    );

    id_checker u_checker (
        .clk(clk), .check_en_i(check_en), .exp_inst_i(inst),
        .exp_flags_i(exp_flags), .exp_target_i(exp_target), .exp_id_ex_i(exp_id_ex),
        .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
        .reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
        .stall_o(stall), .branch_flag_o(branch_flag),
        .branch_target_o(branch_target), .id_ex_o(id_ex),
        .checks_o(checks), .errors_o(errors)
    );

    function automatic word_t enc_r(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                    logic [4:0] rd, logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic id_ex_t ie(alu_op_e op, alu_sel_e sel, word_t a, word_t b,
                                  logic w, reg_addr_t wd, word_t link);
        id_ex_t r;
        r = '0;
        r.aluop = op;
        r.alusel = sel;
        r.reg1 = a;
        r.reg2 = b;
        r.wreg = w;
        r.wd = wd;
        r.link_addr = link;
        return r;
    endfunction

    // fl is {reg1_read, reg2_read, stall, branch_flag}
    task automatic add_row(word_t i, word_t r1d, word_t r2d, logic [3:0] fl, word_t tgt,
                           id_ex_t idex);
        row_t r;
        r = '{inst: i, pc: cur_pc, r1d: r1d, r2d: r2d, ex: cur_ex, mem: cur_mem,
              rnd: cur_rnd, fl: fl, tgt: tgt, idex: idex};
        // stalled cycle loads an all-zero bubble, otherwise inst passes through
        if (fl[1]) r.idex = '0;
        else r.idex.inst = i;
        rows.push_back(r);
    endtask

    task automatic apply_row(row_t r);
        inst = r.inst;
        pc = r.pc;
        reg1_data = r.rnd ? $random(seed) : r.r1d;
        reg2_data = r.rnd ? $random(seed) : r.r2d;
        ex_fwd = r.ex;
        mem_fwd = r.mem;
        exp_flags = r.fl;
        exp_target = r.tgt;
        exp_id_ex = r.idex;
    endtask

    task automatic build_table();
        cur_pc = PC0;
        cur_ex = '0;
        cur_mem = '0;
        cur_rnd = 1'b1;
        // undecodable word decodes as a bubble
        add_row(32'hfc00_0000, 0, 0, 4'b0000, 0, ie(ALU_NOP, SEL_NOP, 0, 0, 0, 0, 0));
        cur_rnd = 1'b0;
        add_row(enc_r(FN_ADD, 1, 2, 3, 0), R1, R2, 4'b1100, 0,
                ie(ALU_ADD, SEL_ARITH, R1, R2, 1, 3, 0));
        add_row(enc_r(FN_NOR, 1, 2, 3, 0), R1, R2, 4'b1100, 0,
                ie(ALU_NOR, SEL_LOGIC, R1, R2, 1, 3, 0));
        add_row(enc_r(FN_SUBU, 1, 2, 3, 0), R1, R2, 4'b1100, 0,
                ie(ALU_SUBU, SEL_ARITH, R1, R2, 1, 3, 0));
        add_row(enc_r(FN_SLTU, 1, 2, 3, 0), R1, R2, 4'b1100, 0,
                ie(ALU_SLTU, SEL_ARITH, R1, R2, 1, 3, 0));
        add_row(enc_r(FN_SRLV, 1, 2, 3, 0), R1, R2, 4'b1100, 0,
                ie(ALU_SRL, SEL_SHIFT, R1, R2, 1, 3, 0));
        // fixed shift carries shamt on the unread port
        add_row(enc_r(FN_SRA, 0, 2, 3, 5), R1, R2, 4'b0100, 0,
                ie(ALU_SRA, SEL_SHIFT, 5, R2, 1, 3, 0));
        add_row(enc_i(OP_ANDI, 1, 2, 16'h8001), R1, R2, 4'b1000, 0,
                ie(ALU_AND, SEL_LOGIC, R1, 32'h0000_8001, 1, 2, 0));
        add_row(enc_i(OP_XORI, 1, 2, 16'hf0f0), R1, R2, 4'b1000, 0,
                ie(ALU_XOR, SEL_LOGIC, R1, 32'h0000_f0f0, 1, 2, 0));
        add_row(enc_i(OP_ADDI, 1, 2, 16'h8001), R1, R2, 4'b1000, 0,
                ie(ALU_ADDI, SEL_ARITH, R1, 32'hffff_8001, 1, 2, 0));
        add_row(enc_i(OP_SLTI, 1, 2, 16'hfffe), R1, R2, 4'b1000, 0,
                ie(ALU_SLT, SEL_ARITH, R1, 32'hffff_fffe, 1, 2, 0));
        add_row(enc_i(OP_LUI, 0, 2, 16'h1234), 0, R2, 4'b1000, 0,
                ie(ALU_OR, SEL_LOGIC, 0, 32'h1234_0000, 1, 2, 0));
        // forwarding priority
        cur_ex = '{ALU_ADD, 1'b1, 5'd1, 32'haaaa_0001};
        cur_mem = '{ALU_NOP, 1'b1, 5'd1, 32'hbbbb_0001};
        add_row(enc_r(FN_ADD, 1, 2, 3, 0), R1, R2, 4'b1100, 0,
                ie(ALU_ADD, SEL_ARITH, 32'haaaa_0001, R2, 1, 3, 0));
        cur_ex.wreg = 1'b0;
        add_row(enc_r(FN_ADD, 1, 2, 3, 0), R1, R2, 4'b1100, 0,
                ie(ALU_ADD, SEL_ARITH, 32'hbbbb_0001, R2, 1, 3, 0));
        cur_ex = '{ALU_ADDU, 1'b1, 5'd2, 32'haaaa_0002};
        cur_mem = '{ALU_NOP, 1'b1, 5'd2, 32'hbbbb_0002};
        add_row(enc_r(FN_ADD, 1, 2, 3, 0), R1, R2, 4'b1100, 0,
                ie(ALU_ADD, SEL_ARITH, R1, 32'haaaa_0002, 1, 3, 0));
        add_row(enc_i(OP_ADDI, 1, 2, 16'h0010), R1, R2, 4'b1000, 0,
                ie(ALU_ADDI, SEL_ARITH, R1, 32'h10, 1, 2, 0));
        // load-use hazard
        cur_ex = '{ALU_LW, 1'b1, 5'd2, 32'hdead_0000};
        cur_mem = '0;
        cur_rnd = 1'b1;
        add_row(enc_r(FN_ADD, 1, 2, 3, 0), R1, R2, 4'b1110, 0, '0);
        cur_rnd = 1'b0;
        add_row(enc_i(OP_ADDI, 1, 2, 16'h0010), R1, R2, 4'b1000, 0,
                ie(ALU_ADDI, SEL_ARITH, R1, 32'h10, 1, 2, 0));
        cur_ex = '{ALU_LB, 1'b1, 5'd1, 32'hdead_0001};
        cur_rnd = 1'b1;
        add_row(enc_i(OP_SW, 1, 2, 16'h0010), R1, R2, 4'b1110, 0, '0);
        // jumps, upper pc bits come from pc+4
        cur_ex = '0;
        cur_pc = 32'h9000_0000;
        add_row({OP_J, 26'h012_3456}, 0, 0, 4'b0001, 32'h9048_d158,
                ie(ALU_J, JB, 0, 0, 0, 0, 0));
        add_row({OP_JAL, 26'h012_3456}, 0, 0, 4'b0001, 32'h9048_d158,
                ie(ALU_JAL, JB, 0, 0, 1, 31, 32'h9000_0008));
        cur_pc = PC0;
        cur_rnd = 1'b0;
        add_row(enc_r(FN_JR, 1, 0, 0, 0), 32'h0040_1000, R2, 4'b1001, 32'h0040_1000,
                ie(ALU_JR, JB, 32'h0040_1000, 0, 0, 0, 0));
        add_row(enc_r(FN_JALR, 1, 0, 31, 0), 32'h0040_1000, R2, 4'b1001, 32'h0040_1000,
                ie(ALU_JALR, JB, 32'h0040_1000, 0, 1, 31, P8));
        add_row(enc_i(OP_BEQ, 1, 2, 16'h0010), 32'h55, 32'h55, 4'b1101, 32'h0040_0144,
                ie(ALU_BEQ, JB, 32'h55, 32'h55, 0, 0, 0));
        add_row(enc_i(OP_BEQ, 1, 2, 16'h0010), 32'h55, 32'h56, 4'b1100, 0,
                ie(ALU_BEQ, JB, 32'h55, 32'h56, 0, 0, 0));
        add_row(enc_i(OP_BNE, 1, 2, 16'hfffc), 1, 2, 4'b1101, 32'h0040_00f4,
                ie(ALU_BNE, JB, 1, 2, 0, 0, 0));
        add_row(enc_i(OP_BNE, 1, 2, 16'hfffc), 7, 7, 4'b1100, 0,
                ie(ALU_BNE, JB, 7, 7, 0, 0, 0));
        add_row(enc_i(OP_BGTZ, 1, 0, 16'h0008), 5, R2, 4'b1001, 32'h0040_0124,
                ie(ALU_BGTZ, JB, 5, 0, 0, 0, 0));
        add_row(enc_i(OP_BGTZ, 1, 0, 16'h0008), 0, R2, 4'b1000, 0,
                ie(ALU_BGTZ, JB, 0, 0, 0, 0, 0));
        add_row(enc_i(OP_BLEZ, 1, 0, 16'h0004), 0, R2, 4'b1001, 32'h0040_0114,
                ie(ALU_BLEZ, JB, 0, 0, 0, 0, 0));
        add_row(enc_i(OP_BLEZ, 1, 0, 16'h0004), 1, R2, 4'b1000, 0,
                ie(ALU_BLEZ, JB, 1, 0, 0, 0, 0));
        add_row(enc_i(OP_REGIMM, 1, 5'h00, 16'h0002), 32'h8000_0000, R2, 4'b1001,
                32'h0040_010c, ie(ALU_BLTZ, JB, 32'h8000_0000, 0, 0, 0, 0));
        add_row(enc_i(OP_REGIMM, 1, 5'h00, 16'h0002), 0, R2, 4'b1000, 0,
                ie(ALU_BLTZ, JB, 0, 0, 0, 0, 0));
        add_row(enc_i(OP_REGIMM, 1, 5'h01, 16'h0002), 0, R2, 4'b1001, 32'h0040_010c,
                ie(ALU_BGEZ, JB, 0, 0, 0, 0, 0));
        add_row(enc_i(OP_REGIMM, 1, 5'h01, 16'h0002), 32'hffff_ffff, R2, 4'b1000, 0,
                ie(ALU_BGEZ, JB, 32'hffff_ffff, 0, 0, 0, 0));
        add_row(enc_i(OP_REGIMM, 1, 5'h10, 16'h0002), 32'h8000_0000, R2, 4'b1001,
                32'h0040_010c, ie(ALU_BLTZAL, JB, 32'h8000_0000, 0, 1, 31, P8));
        add_row(enc_i(OP_REGIMM, 1, 5'h11, 16'h0002), 32'h8000_0000, R2, 4'b1000, 0,
                ie(ALU_BGEZAL, JB, 32'h8000_0000, 0, 1, 31, P8));
        // branch compares the forwarded value
        cur_ex = '{ALU_ADD, 1'b1, 5'd1, 32'h77};
        add_row(enc_i(OP_BEQ, 1, 2, 16'h0010), 32'h11, 32'h77, 4'b1101, 32'h0040_0144,
                ie(ALU_BEQ, JB, 32'h77, 32'h77, 0, 0, 0));
        cur_ex = '0;
        add_row(enc_i(OP_LW, 1, 2, 16'h0010), R1, R2, 4'b1000, 0,
                ie(ALU_LW, LS, R1, 0, 1, 2, 0));
        add_row(enc_i(OP_LBU, 1, 2, 16'h0010), R1, R2, 4'b1000, 0,
                ie(ALU_LBU, LS, R1, 0, 1, 2, 0));
        add_row(enc_i(OP_LH, 1, 2, 16'h0010), R1, R2, 4'b1000, 0,
                ie(ALU_LH, LS, R1, 0, 1, 2, 0));
        add_row(enc_i(OP_SW, 1, 2, 16'h0010), R1, R2, 4'b1100, 0,
                ie(ALU_SW, LS, R1, R2, 0, 0, 0));
        add_row(enc_i(OP_SB, 1, 2, 16'h0010), R1, R2, 4'b1100, 0,
                ie(ALU_SB, LS, R1, R2, 0, 0, 0));
    endtask

    initial begin
        rst_i = 1'b1;
        check_en = 1'b0;
        pc = '0;
        inst = '0;
        reg1_data = '0;
        reg2_data = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        exp_flags = '0;
        exp_target = '0;
        exp_id_ex = '0;
        build_table();
        rows_loaded = 1'b1;
        // a real instruction under reset must still decode as inactive
        inst = enc_r(FN_ADD, 1, 2, 3, 0);
        ex_fwd = '{ALU_LW, 1'b1, 5'd1, 32'h0};
        check_en = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
            @(negedge clk);
        end
        check_en = 1'b0;
        @(posedge clk);
        @(negedge clk);
        $display("checks %0d errors %0d assertion failures %0d", checks, errors,
                 dut.u_id_props.fail_count);
        if (errors == 0 && dut.u_id_props.fail_count == 0 && checks > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (rows_loaded);
        #((rows.size() + 40) * 8);
        $display("timeout: the stimulus table did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
id_pkg.sv
inst_decoder.sv
operand_forward.sv
branch_resolve.sv
id_ex_reg.sv
id_stage.sv
id_props.sv
id_checker.sv
tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - id_pkg.sv
  - inst_decoder.sv
  - operand_forward.sv
  - branch_resolve.sv
  - id_ex_reg.sv
  - id_stage.sv
  - target: simulation
    files:
      - id_props.sv
      - id_checker.sv
      - tb_id_stage.sv
